// ==== design/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

   ////////////////////////////////////////////////////////////
   // Bus widths
   ////////////////////////////////////////////////////////////

   // Console address bus
   localparam int unsigned CONSOLE_AW = 24;

   // Byte lanes everywhere
   localparam int unsigned DATA_W = 8;

   ////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////

   // Address mapping selected by the mcu
   typedef enum logic [1:0] {
      MAP_HIROM = 2'd0,
      MAP_LOROM = 2'd1
   } mapper_t;

   // Owner of the SRAM address bus
   typedef enum logic {
      PHASE_CONSOLE = 1'b0,
      PHASE_MCU     = 1'b1
   } phase_t;

   // Sequencer slots, idle parks on the last code
   typedef enum logic [2:0] {
      SLOT_0    = 3'd0,
      SLOT_1    = 3'd1,
      SLOT_2    = 3'd2,
      SLOT_3    = 3'd3,
      SLOT_4    = 3'd4,
      SLOT_5    = 3'd5,
      SLOT_6    = 3'd6,
      SLOT_IDLE = 3'd7
   } slot_t;

endpackage

`default_nettype wire

// ==== design/addr_mapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module addr_mapper #(
   parameter int unsigned        SRAM_AW   = 21,
   parameter logic [SRAM_AW-1:0] SAVE_BASE = 21'h1F_E000
) (
   input  wire                             CLK,
   input  wire                             rst_n,
   input  wire cart_pkg::mapper_t          mapper,
   input  wire [cart_pkg::CONSOLE_AW-1:0]  cons_addr,
   input  wire cart_pkg::phase_t           phase,
   input  wire                             mcu_next,
   input  wire                             mcu_addr_en,
   input  wire                             mcu_addr_rst,
   input  wire [1:0]                       mcu_bank,
   output logic [SRAM_AW-1:0]              sram_addr,
   output logic                            is_rom,
   output logic                            is_saveram
);

   import cart_pkg::*;

   // Bank bits joined to the low 15 address bits
   localparam int unsigned LOROM_W = CONSOLE_AW - 1;

   logic [SRAM_AW-1:0] save_addr;
   logic [SRAM_AW-1:0] hirom_addr;
   logic [LOROM_W-1:0] lorom_full;
   logic [SRAM_AW-1:0] lorom_addr;
   logic [SRAM_AW-1:0] cons_map;
   logic               hi_save;
   logic               hi_rom;
   logic               lo_save;
   logic               lo_rom;
   logic [2:0]         next_sync;
   logic               next_rise;
   logic [SRAM_AW-1:0] mcu_addr;

   ////////////////////////////////////////////////////////////
   // Console address decode
   ////////////////////////////////////////////////////////////

   // Save RAM window is 8 KB at the top of the SRAM
   assign save_addr  = SAVE_BASE + SRAM_AW'(cons_addr[12:0]);
   assign hirom_addr = cons_addr[SRAM_AW-1:0];
   assign lorom_full = {cons_addr[CONSOLE_AW-1:16], cons_addr[14:0]};
   assign lorom_addr = lorom_full[SRAM_AW-1:0];

   // HiROM save RAM sits at $6000-$7FFF in the lower banks
   assign hi_save = !cons_addr[22] && (cons_addr[15:13] == 3'b011);
   assign hi_rom  = !hi_save && (cons_addr[22] || cons_addr[15]);

   // LoROM save RAM lives in banks $70 and up, lower half only
   assign lo_save = (cons_addr[22:20] == 3'b111) && !cons_addr[15];
   assign lo_rom  = cons_addr[15];

   always_comb begin
      case (mapper)
         MAP_LOROM: begin
            is_saveram = lo_save;
            is_rom     = lo_rom;
            cons_map   = lo_save ? save_addr : lorom_addr;
         end
         // HiROM, also the fallback for unused codes
         default: begin
            is_saveram = hi_save;
            is_rom     = hi_rom;
            cons_map   = hi_save ? save_addr : hirom_addr;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Mcu address counter
   ////////////////////////////////////////////////////////////

   // Two sync stages plus one history stage for edge detect
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         next_sync <= '0;
      end else begin
         next_sync <= {next_sync[1:0], mcu_next};
      end
   end

   assign next_rise = next_sync[1] & ~next_sync[2];

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         mcu_addr <= '0;
      end else if (!mcu_addr_rst) begin
         mcu_addr <= {mcu_bank, {(SRAM_AW-2){1'b0}}};
      end else if (!mcu_addr_en && next_rise) begin
         mcu_addr <= mcu_addr + 1'b1;
      end
   end

   // Bus phase picks who drives the SRAM address
   assign sram_addr = (phase == PHASE_CONSOLE) ? cons_map : mcu_addr;

endmodule

`default_nettype wire

// ==== design/slot_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module slot_sequencer (
   input  wire              CLK,
   input  wire              rst_n,
   input  wire              cons_rd,
   input  wire              cons_wr,
   input  wire              mcu_rd,
   input  wire              mcu_wr,
   input  wire              mcu_ena,
   input  wire              is_saveram,
   output cart_pkg::phase_t phase,
   output logic             sram_oe,
   output logic             sram_we,
   output logic             cons_to_mem,
   output logic             mcu_to_mem,
   output logic             mem_to_cons,
   output logic             mem_to_mcu
);

   import cart_pkg::*;

   slot_t state;
   logic  armed;
   logic  cons_idle;
   logic  start;
   logic  cons_rd_cyc;
   logic  cons_wr_cyc;
   logic  mcu_rd_cyc;
   logic  mcu_wr_cyc;
   logic  cons_wr_save;

   assign cons_idle = cons_rd & cons_wr;

   // New sequence on a console strobe, once per console cycle
   assign start = (state == SLOT_IDLE) && armed && !cons_idle && mcu_ena;

   ////////////////////////////////////////////////////////////
   // Slot counter and arming
   ////////////////////////////////////////////////////////////

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         state <= SLOT_IDLE;
      end else begin
         case (state)
            SLOT_IDLE: begin
               if (start) begin
                  state <= SLOT_0;
               end
            end
            SLOT_6:  state <= SLOT_IDLE;
            default: state <= slot_t'(state + 3'd1);
         endcase
      end
   end

   // Held strobes must go back high before the next start
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         armed <= 1'b1;
      end else if (start) begin
         armed <= 1'b0;
      end else if (cons_idle) begin
         armed <= 1'b1;
      end
   end

   // Cycle type is frozen once the sequence leaves idle
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         cons_rd_cyc <= 1'b1;
         cons_wr_cyc <= 1'b1;
         mcu_rd_cyc  <= 1'b1;
         mcu_wr_cyc  <= 1'b1;
      end else if (state == SLOT_IDLE) begin
         cons_rd_cyc <= cons_rd;
         cons_wr_cyc <= cons_wr;
         mcu_rd_cyc  <= mcu_rd;
         mcu_wr_cyc  <= mcu_wr;
      end
   end

   // Console writes only reach save RAM
   assign cons_wr_save = !cons_wr_cyc && is_saveram;

   ////////////////////////////////////////////////////////////
   // Strobe tables
   ////////////////////////////////////////////////////////////

   always_comb begin
      phase       = PHASE_MCU;
      sram_oe     = 1'b1;
      sram_we     = 1'b1;
      cons_to_mem = 1'b0;
      mcu_to_mem  = 1'b0;
      mem_to_cons = 1'b0;
      mem_to_mcu  = 1'b0;
      case (state)
         SLOT_0: begin
            phase       = PHASE_CONSOLE;
            sram_oe     = cons_rd_cyc;
            cons_to_mem = cons_wr_save;
         end
         SLOT_1: begin
            phase   = PHASE_CONSOLE;
            sram_oe = cons_rd_cyc;
            sram_we = !cons_wr_save;
         end
         SLOT_2: begin
            phase       = PHASE_CONSOLE;
            sram_oe     = cons_rd_cyc;
            sram_we     = !cons_wr_save;
            mem_to_cons = !cons_rd_cyc;
         end
         // Turnaround before the mcu slots
         SLOT_3: phase = PHASE_CONSOLE;
         SLOT_4: begin
            sram_oe    = mcu_rd_cyc;
            mcu_to_mem = !mcu_wr_cyc;
         end
         SLOT_5: begin
            sram_oe    = mcu_rd_cyc;
            sram_we    = mcu_wr_cyc;
            mem_to_mcu = !mcu_rd_cyc;
         end
         default: ;
      endcase

      // Direct mode hands the SRAM to the mcu strobes
      if (!mcu_ena) begin
         phase       = PHASE_MCU;
         sram_oe     = mcu_rd;
         sram_we     = mcu_wr;
         cons_to_mem = 1'b0;
         mem_to_cons = 1'b0;
         mcu_to_mem  = 1'b1;
         mem_to_mcu  = !mcu_rd;
      end
   end

endmodule

`default_nettype wire

// ==== design/data_latch.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_latch (
   input  wire                          CLK,
   input  wire                          rst_n,
   input  wire [cart_pkg::DATA_W-1:0]   cons_wdata,
   input  wire [cart_pkg::DATA_W-1:0]   mcu_wdata,
   input  wire [cart_pkg::DATA_W-1:0]   sram_rdata,
   input  wire                          cons_to_mem,
   input  wire                          mcu_to_mem,
   input  wire                          mem_to_cons,
   input  wire                          mem_to_mcu,
   input  wire                          cons_rd,
   input  wire                          cons_wr,
   input  wire                          cons_cs,
   input  wire                          is_rom,
   input  wire                          is_saveram,
   output logic [cart_pkg::DATA_W-1:0]  sram_wdata,
   output logic [cart_pkg::DATA_W-1:0]  cons_rdata,
   output logic [cart_pkg::DATA_W-1:0]  mcu_rdata,
   output logic                         cons_data_oe,
   output logic                         cons_data_dir
);

   ////////////////////////////////////////////////////////////
   // Data registers
   ////////////////////////////////////////////////////////////

   // Shared write register, console slot wins on overlap
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         sram_wdata <= '0;
      end else if (cons_to_mem) begin
         sram_wdata <= cons_wdata;
      end else if (mcu_to_mem) begin
         sram_wdata <= mcu_wdata;
      end
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         cons_rdata <= '0;
      end else if (mem_to_cons) begin
         cons_rdata <= sram_rdata;
      end
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         mcu_rdata <= '0;
      end else if (mem_to_mcu) begin
         mcu_rdata <= sram_rdata;
      end
   end

   ////////////////////////////////////////////////////////////
   // Console bus buffer control
   ////////////////////////////////////////////////////////////

   // Only drive the console bus for decoded cart regions
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         cons_data_oe <= 1'b1;
      end else begin
         cons_data_oe <= !(!cons_cs && (is_rom || is_saveram) && !(cons_rd && cons_wr));
      end
   end

   // Towards the console unless it writes
   assign cons_data_dir = cons_wr;

endmodule

`default_nettype wire

// ==== design/cart_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cart_top #(
   parameter int unsigned        SRAM_AW   = 21,
   parameter logic [SRAM_AW-1:0] SAVE_BASE = 21'h1F_E000
) (
   input  wire                             CLK,
   input  wire                             rst_n,
   input  wire cart_pkg::mapper_t          mapper,
   input  wire [cart_pkg::CONSOLE_AW-1:0]  cons_addr,
   input  wire                             cons_rd,
   input  wire                             cons_wr,
   input  wire                             cons_cs,
   input  wire [cart_pkg::DATA_W-1:0]      cons_wdata,
   output wire [cart_pkg::DATA_W-1:0]      cons_rdata,
   output wire                             cons_data_oe,
   output wire                             cons_data_dir,
   input  wire                             mcu_ena,
   input  wire                             mcu_rd,
   input  wire                             mcu_wr,
   input  wire                             mcu_next,
   input  wire                             mcu_addr_en,
   input  wire                             mcu_addr_rst,
   input  wire [1:0]                       mcu_bank,
   input  wire [cart_pkg::DATA_W-1:0]      mcu_wdata,
   output wire [cart_pkg::DATA_W-1:0]      mcu_rdata,
   output wire [SRAM_AW-1:0]               sram_addr,
   input  wire [cart_pkg::DATA_W-1:0]      sram_rdata,
   output wire [cart_pkg::DATA_W-1:0]      sram_wdata,
   output wire                             sram_oe,
   output wire                             sram_we,
   output wire cart_pkg::phase_t           phase
);

   wire is_rom;
   wire is_saveram;
   wire cons_to_mem;
   wire mcu_to_mem;
   wire mem_to_cons;
   wire mem_to_mcu;

   // Address side, console decode and mcu counter
   addr_mapper #(
      .SRAM_AW   (SRAM_AW),
      .SAVE_BASE (SAVE_BASE)
   ) u_addr_mapper (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .mapper       (mapper),
      .cons_addr    (cons_addr),
      .phase        (phase),
      .mcu_next     (mcu_next),
      .mcu_addr_en  (mcu_addr_en),
      .mcu_addr_rst (mcu_addr_rst),
      .mcu_bank     (mcu_bank),
      .sram_addr    (sram_addr),
      .is_rom       (is_rom),
      .is_saveram   (is_saveram)
   );

   // Time slots and SRAM strobes
   slot_sequencer u_slot_sequencer (
      .CLK         (CLK),
      .rst_n       (rst_n),
      .cons_rd     (cons_rd),
      .cons_wr     (cons_wr),
      .mcu_rd      (mcu_rd),
      .mcu_wr      (mcu_wr),
      .mcu_ena     (mcu_ena),
      .is_saveram  (is_saveram),
      .phase       (phase),
      .sram_oe     (sram_oe),
      .sram_we     (sram_we),
      .cons_to_mem (cons_to_mem),
      .mcu_to_mem  (mcu_to_mem),
      .mem_to_cons (mem_to_cons),
      .mem_to_mcu  (mem_to_mcu)
   );

   // Data path
   data_latch u_data_latch (
      .CLK           (CLK),
      .rst_n         (rst_n),
      .cons_wdata    (cons_wdata),
      .mcu_wdata     (mcu_wdata),
      .sram_rdata    (sram_rdata),
      .cons_to_mem   (cons_to_mem),
      .mcu_to_mem    (mcu_to_mem),
      .mem_to_cons   (mem_to_cons),
      .mem_to_mcu    (mem_to_mcu),
      .cons_rd       (cons_rd),
      .cons_wr       (cons_wr),
      .cons_cs       (cons_cs),
      .is_rom        (is_rom),
      .is_saveram    (is_saveram),
      .sram_wdata    (sram_wdata),
      .cons_rdata    (cons_rdata),
      .mcu_rdata     (mcu_rdata),
      .cons_data_oe  (cons_data_oe),
      .cons_data_dir (cons_data_dir)
   );

endmodule

`default_nettype wire

// ==== tests/tb_cart_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cart_top;

   import cart_pkg::*;

   localparam int unsigned SRAM_AW = 21;
   // Save RAM at the start of mcu bank 2, within a few counter steps
   localparam logic [SRAM_AW-1:0] SAVE_BASE = 21'h10_0000;
   localparam int unsigned CLKS_PER_LINE = 16;
   localparam int unsigned EXTRA_CLKS    = 200;

   logic                  CLK;
   logic                  rst_n;
   mapper_t               mapper;
   logic [CONSOLE_AW-1:0] cons_addr;
   logic                  cons_rd;
   logic                  cons_wr;
   logic                  cons_cs;
   logic [DATA_W-1:0]     cons_wdata;
   logic [DATA_W-1:0]     cons_rdata;
   logic                  cons_data_oe;
   logic                  cons_data_dir;
   logic                  mcu_ena;
   logic                  mcu_rd;
   logic                  mcu_wr;
   logic                  mcu_next;
   logic                  mcu_addr_en;
   logic                  mcu_addr_rst;
   logic [1:0]            mcu_bank;
   logic [DATA_W-1:0]     mcu_wdata;
   logic [DATA_W-1:0]     mcu_rdata;
   logic [SRAM_AW-1:0]    sram_addr;
   logic [DATA_W-1:0]     sram_rdata;
   logic [DATA_W-1:0]     sram_wdata;
   logic                  sram_oe;
   logic                  sram_we;
   phase_t                phase;

   // Only written bytes are stored, the rest comes from the fill pattern
   logic [DATA_W-1:0]     sram_mem [int unsigned];

   logic [3:0]            kind_q [$];
   logic [1:0]            map_q  [$];
   logic [CONSOLE_AW-1:0] addr_q [$];
   logic [DATA_W-1:0]     data_q [$];
   logic [DATA_W-1:0]     exp_q  [$];

   int unsigned cycle_count = 0;
   int unsigned cycle_limit;

   cart_top #(
      .SRAM_AW   (SRAM_AW),
      .SAVE_BASE (SAVE_BASE)
   ) DUT (
      .CLK           (CLK),
      .rst_n         (rst_n),
      .mapper        (mapper),
      .cons_addr     (cons_addr),
      .cons_rd       (cons_rd),
      .cons_wr       (cons_wr),
      .cons_cs       (cons_cs),
      .cons_wdata    (cons_wdata),
      .cons_rdata    (cons_rdata),
      .cons_data_oe  (cons_data_oe),
      .cons_data_dir (cons_data_dir),
      .mcu_ena       (mcu_ena),
      .mcu_rd        (mcu_rd),
      .mcu_wr        (mcu_wr),
      .mcu_next      (mcu_next),
      .mcu_addr_en   (mcu_addr_en),
      .mcu_addr_rst  (mcu_addr_rst),
      .mcu_bank      (mcu_bank),
      .mcu_wdata     (mcu_wdata),
      .mcu_rdata     (mcu_rdata),
      .sram_addr     (sram_addr),
      .sram_rdata    (sram_rdata),
      .sram_wdata    (sram_wdata),
      .sram_oe       (sram_oe),
      .sram_we       (sram_we),
      .phase         (phase)
   );

   always #2 CLK = ~CLK;

   ////////////////////////////////////////////////////////////
   // SRAM model
   ////////////////////////////////////////////////////////////

   function automatic logic [DATA_W-1:0] fill_byte(input logic [SRAM_AW-1:0] a);
      return a[7:0] ^ a[15:8] ^ {3'b000, a[20:16]};
   endfunction

   always @(posedge CLK) begin
      if (!sram_we) begin
         sram_mem[sram_addr] = sram_wdata;
      end
   end

   always_comb begin
      if (sram_oe) begin
         sram_rdata = '0;
      end else if (sram_mem.exists(sram_addr)) begin
         sram_rdata = sram_mem[sram_addr];
      end else begin
         sram_rdata = fill_byte(sram_addr);
      end
   end

   ////////////////////////////////////////////////////////////
   // Failure handling and compare tasks
   ////////////////////////////////////////////////////////////

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("ERROR at %0t: %s expected %02h, got %02h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_phase(input string name, input phase_t exp, input phase_t act);
      if (act !== exp) begin
         $display("ERROR at %0t: %s expected %s, got %s", $time, name, exp.name(),
                  act.name());
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
         abort_run();
      end
   endtask

   // Hard stop if the tests run far past their expected length
   always @(posedge CLK) begin
      cycle_count++;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
         $display("Timeout: tests still running after %0d clocks", cycle_count);
         abort_run();
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus tasks, all start and end just after a falling edge
   ////////////////////////////////////////////////////////////

   task automatic load_testdata();
      int                    fd;
      int                    n;
      string                 line;
      logic [3:0]            k;
      logic [1:0]            m;
      logic [CONSOLE_AW-1:0] a;
      logic [DATA_W-1:0]     d;
      logic [DATA_W-1:0]     e;
      fd = $fopen("tests/cart_testdata.txt", "r");
      if (fd == 0) begin
         $display("Cannot open tests/cart_testdata.txt for reading");
         abort_run();
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 0 && line.getc(0) != "#") begin
            if ($sscanf(line, "%h %h %h %h %h", k, m, a, d, e) == 5) begin
               kind_q.push_back(k);
               map_q.push_back(m);
               addr_q.push_back(a);
               data_q.push_back(d);
               exp_q.push_back(e);
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic reset_counter(input logic [1:0] bank);
      mcu_bank     = bank;
      mcu_addr_rst = 1'b0;
      @(negedge CLK);
      mcu_addr_rst = 1'b1;
   endtask

   // Two sync flops plus edge detect, so three clocks each way
   task automatic step_counter();
      mcu_next = 1'b1;
      repeat (3) @(negedge CLK);
      mcu_next = 1'b0;
      repeat (3) @(negedge CLK);
   endtask

   task automatic mcu_direct_write(input logic [DATA_W-1:0] wdata);
      mcu_ena   = 1'b0;
      mcu_wdata = wdata;
      @(negedge CLK);
      mcu_wr = 1'b0;
      @(negedge CLK);
      mcu_wr    = 1'b1;
      mcu_ena   = 1'b1;
      mcu_wdata = DATA_W'($urandom);
   endtask

   task automatic mcu_direct_read(input logic [DATA_W-1:0] exp);
      mcu_ena = 1'b0;
      mcu_rd  = 1'b0;
      @(negedge CLK);
      mcu_rd  = 1'b1;
      mcu_ena = 1'b1;
      check_byte("mcu_rdata", exp, mcu_rdata);
   endtask

   task automatic console_cycle(
      input logic                  is_write,
      input mapper_t               map,
      input logic [CONSOLE_AW-1:0] addr,
      input logic [DATA_W-1:0]     wdata,
      input logic                  with_mcu_read,
      input int                    hold
   );
      int   falls;
      int   gap;
      logic prev_oe;
      falls      = 0;
      prev_oe    = 1'b1;
      mapper     = map;
      cons_addr  = addr;
      cons_cs    = 1'b0;
      cons_wdata = is_write ? wdata : DATA_W'($urandom);
      cons_rd    = is_write;
      cons_wr    = !is_write;
      mcu_rd     = !with_mcu_read;
      for (int i = 1; i <= hold; i++) begin
         @(negedge CLK);
         if (prev_oe && !sram_oe) begin
            falls++;
         end
         prev_oe = sram_oe;
         // Slots 0 to 3 follow the sampling edge
         check_phase("phase", (i <= 4) ? PHASE_CONSOLE : PHASE_MCU, phase);
         if (i == 1) begin
            check_bit("cons_data_oe", 1'b0, cons_data_oe);
            check_bit("cons_data_dir", !is_write, cons_data_dir);
         end
      end
      cons_rd = 1'b1;
      cons_wr = 1'b1;
      cons_cs = 1'b1;
      mcu_rd  = 1'b1;
      // One oe burst per console read, another for an mcu read
      check_count("sram_oe falling edges", (is_write ? 0 : 1) + (with_mcu_read ? 1 : 0),
                  falls);
      gap = 2 + int'($urandom % 3);
      repeat (gap) @(negedge CLK);
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(32'haf00_98b0));
      cycle_limit  = 0;
      CLK          = 1'b0;
      rst_n        = 1'b0;
      mapper       = MAP_HIROM;
      cons_addr    = '0;
      cons_rd      = 1'b1;
      cons_wr      = 1'b1;
      cons_cs      = 1'b1;
      cons_wdata   = '0;
      mcu_ena      = 1'b1;
      mcu_rd       = 1'b1;
      mcu_wr       = 1'b1;
      mcu_next     = 1'b0;
      mcu_addr_en  = 1'b0;
      mcu_addr_rst = 1'b1;
      mcu_bank     = 2'd0;
      mcu_wdata    = '0;

      load_testdata();
      if (kind_q.size() == 0) begin
         $display("No test lines found in tests/cart_testdata.txt");
         abort_run();
      end
      cycle_limit = kind_q.size() * CLKS_PER_LINE + EXTRA_CLKS;

      repeat (2) @(negedge CLK);
      rst_n = 1'b1;
      @(negedge CLK);
      check_bit("sram_oe", 1'b1, sram_oe);
      check_bit("sram_we", 1'b1, sram_we);
      check_bit("cons_data_oe", 1'b1, cons_data_oe);
      check_phase("phase", PHASE_MCU, phase);

      for (int i = 0; i < kind_q.size(); i++) begin
         case (kind_q[i])
            4'h1: reset_counter(addr_q[i][1:0]);
            4'h2: begin
               mcu_direct_write(data_q[i]);
               step_counter();
            end
            4'h3: begin
               mcu_direct_read(exp_q[i]);
               step_counter();
            end
            4'h4: begin
               console_cycle(1'b0, mapper_t'(map_q[i]), addr_q[i], 8'h00, 1'b0, 8);
               check_byte("cons_rdata", exp_q[i], cons_rdata);
            end
            4'h5: console_cycle(1'b1, mapper_t'(map_q[i]), addr_q[i], data_q[i], 1'b0, 8);
            4'h6: begin
               console_cycle(1'b0, mapper_t'(map_q[i]), addr_q[i], 8'h00, 1'b1, 8);
               check_byte("cons_rdata", exp_q[i], cons_rdata);
               check_byte("mcu_rdata", data_q[i], mcu_rdata);
            end
            4'h7: begin
               console_cycle(1'b0, mapper_t'(map_q[i]), addr_q[i], 8'h00, 1'b0, 16);
               check_byte("cons_rdata", exp_q[i], cons_rdata);
            end
            default: begin
               $display("Unknown access kind %0h on test line %0d", kind_q[i], i);
               abort_run();
            end
         endcase
      end

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/cart_testdata.txt ====
# kind mapper address data expected, all hex; kinds 1 counter bank, 2 mcu write, 3 mcu read,
# 4 console read, 5 console write, 6 console read plus mcu read (data = mcu byte), 7 long read
1 0 000001 00 00
2 0 000000 3C 00
2 0 000000 A5 00
2 0 000000 5A 00
2 0 000000 C3 00
1 0 000001 00 00
3 0 000000 00 3C
3 0 000000 00 A5
3 0 000000 00 5A
3 0 000000 00 C3
4 0 C01234 00 26
4 0 3F8765 00 FD
4 0 E54321 00 67
4 1 01ABCD 00 66
4 1 23F00F 00 EE
4 1 7D9A5C 00 D8
5 0 306002 9E 00
5 1 700005 4B 00
5 0 C05577 99 00
4 0 C05577 00 22
4 0 306002 00 9E
1 0 000002 00 00
3 0 000000 00 10
3 0 000000 00 11
3 0 000000 00 9E
3 0 000000 00 13
3 0 000000 00 14
3 0 000000 00 4B
1 0 000001 00 00
6 0 C2ABCD 3C 64
7 1 058123 00 A0
4 0 3F8765 00 FD

// ==== vlog.f ====
design/cart_pkg.sv
design/addr_mapper.sv
design/slot_sequencer.sv
design/data_latch.sv
design/cart_top.sv
tests/tb_cart_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cartridge controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_cart_top -f vlog.f -o tb_cart_top
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_cart_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
